// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ======================================================================
// Core widths
// ======================================================================
`define XLEN        32      // Data and address width
`define REG_ADDR_W  5       // Register index width
`define REG_COUNT   32      // General registers, $0 included

// First fetch after reset
`define RESET_PC    32'h3000

// ======================================================================
// Data memory
// ======================================================================
`define DMEM_WORDS  64      // Depth in words
`define DMEM_ADDR_W 6       // Word index bits, above the byte offset

`endif

// ==== logic/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

	// ======================================================================
	// Encodings
	// ======================================================================

	// Instruction kinds, zero is nop so a cleared ctrl is a bubble
	typedef enum logic [2:0] {
		opNop,
		opAddu,
		opSubu,
		opOri,
		opLui,
		opLw,
		opSw,
		opBeq
	} opcodeT;

	typedef enum logic [1:0] {
		aluAdd,     // Also load and store address
		aluSub,
		aluOr,
		aluLui      // Immediate into upper half
	} aluOpT;

	// Source of a corrected operand
	typedef enum logic [1:0] {
		fwdReg,     // Value the stage already holds
		fwdFromE,
		fwdFromM,
		fwdFromW
	} fwdSelT;

	// Pipeline stage numbers, ordered so they compare as timing
	typedef enum logic [2:0] {
		stgNone = 3'd0,
		stgD    = 3'd1,
		stgE    = 3'd2,
		stgM    = 3'd3,
		stgW    = 3'd4
	} stageT;

	// ======================================================================
	// Control and pipeline records
	// ======================================================================
	typedef struct packed {
		opcodeT                 kind;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] dest;
		logic                   regWrite;    // Never set with dest 0
		logic                   useImm;      // Operand B from immediate
		logic                   zeroExt;
		aluOpT                  aluOp;
		logic                   memRead;
		logic                   memWrite;
		stageT                  rsUseStage;  // First stage needing rs
		stageT                  rtUseStage;
		stageT                  resultStage; // Stage that computes the result
	} ctrlT;

	typedef struct packed {
		ctrlT             ctrl;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] rsVal;
		logic [`XLEN-1:0] rtVal;
		logic [`XLEN-1:0] immExt;
	} deRegT;

	typedef struct packed {
		ctrlT             ctrl;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] aluResult;  // Also the memory address
		logic [`XLEN-1:0] rtVal;
	} emRegT;

	typedef struct packed {
		ctrlT             ctrl;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] result;     // ALU result or load data
	} mwRegT;

	// Retired writes, one-cycle strobes
	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       pc;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0]       data;
	} regWriteT;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] addr;   // Byte address
		logic [`XLEN-1:0] data;
	} memWriteT;

endpackage

// ==== logic/dataMem.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module dataMem (
	input  logic             clk,
	input  logic             rstN,
	input  logic [`XLEN-1:0] addr,    // Byte address, word aligned
	input  logic [`XLEN-1:0] wData,
	input  logic             we,
	output logic [`XLEN-1:0] rData
);

	logic [`XLEN-1:0]        mem [`DMEM_WORDS];
	logic [`DMEM_ADDR_W-1:0] wordIdx;

	assign wordIdx = addr[`DMEM_ADDR_W+1:2];   // Drop byte offset

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (we) begin
			mem[wordIdx] <= wData;
		end
	end

	// Asynchronous read within M
	assign rData = mem[wordIdx];

endmodule

// ==== logic/execUnit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module execUnit import cpu_pkg::*; (
	input  ctrlT             ctrl,
	input  logic [`XLEN-1:0] opA,      // Forwarded rs
	input  logic [`XLEN-1:0] rtVal,    // Forwarded rt
	input  logic [`XLEN-1:0] immExt,
	output logic [`XLEN-1:0] result
);

	logic [`XLEN-1:0] opB;

	assign opB = ctrl.useImm ? immExt : rtVal;

	// ======================================================================
	// ALU, no overflow trap
	// ======================================================================
	always_comb begin
		case (ctrl.aluOp)
			aluAdd:  result = opA + opB;    // addu, lw, sw
			aluSub:  result = opA - opB;
			aluOr:   result = opA | opB;
			aluLui:  result = {immExt[15:0], {(`XLEN-16){1'b0}}};
			default: result = opA + opB;
		endcase
	end

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetchUnit (
	input  logic             clk,
	input  logic             rstN,
	input  logic             stall,
	input  logic             branchTaken,
	input  logic [`XLEN-1:0] branchPc,   // PC of the beq in decode
	input  logic [15:0]      imm,
	output logic [`XLEN-1:0] pc
);

	logic [`XLEN-1:0] offset;
	logic [`XLEN-1:0] target;

	// Word offset, sign extended
	assign offset = {{(`XLEN-18){imm[15]}}, imm, 2'b00};
	assign target = branchPc + 4 + offset;

	// ======================================================================
	// Program counter
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (!stall) begin    // Stall wins over a branch
			if (branchTaken)
				pc <= target;           // Delay slot already fetched
			else
				pc <= pc + 4;
		end
	end

endmodule

// ==== logic/hazardUnit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module hazardUnit import cpu_pkg::*; (
	input  ctrlT   dCtrl,
	input  ctrlT   eCtrl,
	input  ctrlT   mCtrl,
	input  ctrlT   wCtrl,
	output logic   stall,    // Also the execute bubble
	output fwdSelT fwdDRs,
	output fwdSelT fwdDRt,
	output fwdSelT fwdERs,
	output fwdSelT fwdERt,
	output fwdSelT fwdMRt
);

	// Producer writes this source register
	function automatic logic hits(input ctrlT p, input logic [`REG_ADDR_W-1:0] src);
		return p.regWrite && (p.dest == src);
	endfunction

	// Result already sits in the register feeding stage pos
	function automatic logic readyIn(input ctrlT p, input stageT pos);
		return int'(p.resultStage) < int'(pos);
	endfunction

	// Still missing once the decode consumer reaches useAt
	function automatic logic lateFor(input ctrlT p, input stageT pos, input stageT useAt);
		return int'(p.resultStage) >= int'(pos) + int'(useAt) - int'(stgD);
	endfunction

	// Youngest producer decides, an older one is never used past it
	function automatic fwdSelT pickSrc(input logic hitE, input logic rdyE,
			input logic hitM, input logic rdyM, input logic hitW, input logic rdyW);
		if (hitE)
			return rdyE ? fwdFromE : fwdReg;
		if (hitM)
			return rdyM ? fwdFromM : fwdReg;
		if (hitW)
			return rdyW ? fwdFromW : fwdReg;
		return fwdReg;
	endfunction

	function automatic logic opStall(input logic [`REG_ADDR_W-1:0] src, input stageT useAt,
			input ctrlT eC, input ctrlT mC, input ctrlT wC);
		logic late;
		late = 1'b0;
		if (useAt != stgNone) begin
			if (hits(eC, src))
				late = lateFor(eC, stgE, useAt);
			else if (hits(mC, src))
				late = lateFor(mC, stgM, useAt);
			else if (hits(wC, src))
				late = lateFor(wC, stgW, useAt);
		end
		return late;
	endfunction

	// ======================================================================
	// Stall, only the decode instruction can wait
	// ======================================================================
	assign stall = opStall(dCtrl.rs, dCtrl.rsUseStage, eCtrl, mCtrl, wCtrl)
		|| opStall(dCtrl.rt, dCtrl.rtUseStage, eCtrl, mCtrl, wCtrl);

	// ======================================================================
	// Forwarding selects per consumer stage
	// ======================================================================
	assign fwdDRs = pickSrc(hits(eCtrl, dCtrl.rs), readyIn(eCtrl, stgE),
		hits(mCtrl, dCtrl.rs), readyIn(mCtrl, stgM),
		hits(wCtrl, dCtrl.rs), readyIn(wCtrl, stgW));
	assign fwdDRt = pickSrc(hits(eCtrl, dCtrl.rt), readyIn(eCtrl, stgE),
		hits(mCtrl, dCtrl.rt), readyIn(mCtrl, stgM),
		hits(wCtrl, dCtrl.rt), readyIn(wCtrl, stgW));

	// Execute looks at M and W only
	assign fwdERs = pickSrc(1'b0, 1'b0, hits(mCtrl, eCtrl.rs), readyIn(mCtrl, stgM),
		hits(wCtrl, eCtrl.rs), readyIn(wCtrl, stgW));
	assign fwdERt = pickSrc(1'b0, 1'b0, hits(mCtrl, eCtrl.rt), readyIn(mCtrl, stgM),
		hits(wCtrl, eCtrl.rt), readyIn(wCtrl, stgW));

	// Store data in memory, W is the last chance
	assign fwdMRt = pickSrc(1'b0, 1'b0, 1'b0, 1'b0,
		hits(wCtrl, mCtrl.rt), readyIn(wCtrl, stgW));

endmodule

// ==== logic/instrDecode.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module instrDecode import cpu_pkg::*; (
	input  logic [`XLEN-1:0] instr,
	output ctrlT             ctrl
);

	logic [5:0] opField;
	logic [5:0] funct;
	opcodeT     kind;

	assign opField = instr[31:26];
	assign funct   = instr[5:0];

	// Opcode and funct to instruction kind
	always_comb begin
		case (opField)
			6'b000000: begin // SPECIAL
				case (funct)
					6'b100001: kind = opAddu;
					6'b100011: kind = opSubu;
					default:   kind = opNop;   // sll $0 and the rest
				endcase
			end
			6'b001101: kind = opOri;
			6'b001111: kind = opLui;
			6'b100011: kind = opLw;
			6'b101011: kind = opSw;
			6'b000100: kind = opBeq;
			default:   kind = opNop;
		endcase
	end

	// Control record, cleared fields mean no use and no write
	always_comb begin
		ctrl      = '0;
		ctrl.kind = kind;
		ctrl.rs   = instr[25:21];
		ctrl.rt   = instr[20:16];
		case (kind)
			opAddu, opSubu: begin
				ctrl.dest        = instr[15:11];   // rd
				ctrl.regWrite    = 1'b1;
				ctrl.aluOp       = (kind == opSubu) ? aluSub : aluAdd;
				ctrl.rsUseStage  = stgE;
				ctrl.rtUseStage  = stgE;
				ctrl.resultStage = stgE;
			end
			opOri: begin
				ctrl.dest        = instr[20:16];
				ctrl.regWrite    = 1'b1;
				ctrl.useImm      = 1'b1;
				ctrl.zeroExt     = 1'b1;
				ctrl.aluOp       = aluOr;
				ctrl.rsUseStage  = stgE;
				ctrl.resultStage = stgE;
			end
			opLui: begin
				ctrl.dest        = instr[20:16];
				ctrl.regWrite    = 1'b1;
				ctrl.useImm      = 1'b1;
				ctrl.aluOp       = aluLui;      // No register source
				ctrl.resultStage = stgE;
			end
			opLw: begin
				ctrl.dest        = instr[20:16];
				ctrl.regWrite    = 1'b1;
				ctrl.useImm      = 1'b1;
				ctrl.memRead     = 1'b1;
				ctrl.rsUseStage  = stgE;        // Base for address add
				ctrl.resultStage = stgM;        // Data leaves M
			end
			opSw: begin
				ctrl.useImm      = 1'b1;
				ctrl.memWrite    = 1'b1;
				ctrl.rsUseStage  = stgE;
				ctrl.rtUseStage  = stgM;        // Store data late
			end
			opBeq: begin
				ctrl.rsUseStage  = stgD;        // Compare in decode
				ctrl.rtUseStage  = stgD;
			end
			default: ;
		endcase
		// $0 is never a destination
		ctrl.regWrite = ctrl.regWrite && (ctrl.dest != '0);
	end

endmodule

// ==== logic/mipsCore.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module mipsCore import cpu_pkg::*; (
	input  logic             clk,
	input  logic             rstN,
	output logic [`XLEN-1:0] instrAddr,
	input  logic [`XLEN-1:0] instr,     // Same-cycle answer to instrAddr
	output regWriteT         regWrite,
	output memWriteT         memWrite
);

	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] dPc;
	logic [`XLEN-1:0] dInstr, eInstr, mInstr, wInstr;
	ctrlT             dCtrl, eCtrl, mCtrl, wCtrl;
	logic [`XLEN-1:0] rfRs, rfRt;
	logic [`XLEN-1:0] dRs, dRt, dImmExt;
	logic [`XLEN-1:0] eRs, eRt, aluResult;
	logic [`XLEN-1:0] mRt, memRData;
	logic             stall;
	logic             branchTaken;
	fwdSelT           fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt;
	deRegT            deReg;
	emRegT            emReg;
	mwRegT            mwReg;

	// Nothing in this subset produces in decode, so E folds onto own value
	function automatic logic [`XLEN-1:0] fwdPick(input fwdSelT sel,
			input logic [`XLEN-1:0] own, input logic [`XLEN-1:0] fromM,
			input logic [`XLEN-1:0] fromW);
		case (sel)
			fwdFromM: return fromM;
			fwdFromW: return fromW;
			default:  return own;
		endcase
	endfunction

	// ======================================================================
	// Fetch and decode
	// ======================================================================
	assign instrAddr = pc;

	fetchUnit iFetch (.clk(clk), .rstN(rstN), .stall(stall), .branchTaken(branchTaken),
		.branchPc(dPc), .imm(dInstr[15:0]), .pc(pc));

	// Per-stage controllers, the hazard unit reads these
	instrDecode iDecD (.instr(dInstr), .ctrl(dCtrl));
	instrDecode iDecE (.instr(eInstr), .ctrl(eCtrl));
	instrDecode iDecM (.instr(mInstr), .ctrl(mCtrl));
	instrDecode iDecW (.instr(wInstr), .ctrl(wCtrl));

	regFile iRegs (.clk(clk), .rstN(rstN), .rsAddr(dCtrl.rs), .rtAddr(dCtrl.rt),
		.rsData(rfRs), .rtData(rfRt), .wr(regWrite));

	hazardUnit iHazard (.dCtrl(dCtrl), .eCtrl(eCtrl), .mCtrl(mCtrl), .wCtrl(wCtrl),
		.stall(stall), .fwdDRs(fwdDRs), .fwdDRt(fwdDRt), .fwdERs(fwdERs),
		.fwdERt(fwdERt), .fwdMRt(fwdMRt));

	assign dRs = fwdPick(fwdDRs, rfRs, emReg.aluResult, mwReg.result);
	assign dRt = fwdPick(fwdDRt, rfRt, emReg.aluResult, mwReg.result);

	// Branch resolves here, stale operands only while stalled
	assign branchTaken = (dCtrl.kind == opBeq) && (dRs == dRt);

	assign dImmExt = dCtrl.zeroExt ? {{(`XLEN-16){1'b0}}, dInstr[15:0]}
		: {{(`XLEN-16){dInstr[15]}}, dInstr[15:0]};

	// ======================================================================
	// Execute and memory
	// ======================================================================
	assign eRs = fwdPick(fwdERs, deReg.rsVal, emReg.aluResult, mwReg.result);
	assign eRt = fwdPick(fwdERt, deReg.rtVal, emReg.aluResult, mwReg.result);

	execUnit iExec (.ctrl(deReg.ctrl), .opA(eRs), .rtVal(eRt), .immExt(deReg.immExt),
		.result(aluResult));

	// Store data, only W can still correct it
	assign mRt = (fwdMRt == fwdFromW) ? mwReg.result : emReg.rtVal;

	dataMem iDmem (.clk(clk), .rstN(rstN), .addr(emReg.aluResult), .wData(mRt),
		.we(emReg.ctrl.memWrite), .rData(memRData));

	// ======================================================================
	// Pipeline registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			dInstr     <= '0;    // All stages nop
			eInstr     <= '0;
			mInstr     <= '0;
			wInstr     <= '0;
			deReg.ctrl <= '0;
			emReg.ctrl <= '0;
			mwReg.ctrl <= '0;
		end else begin
			if (!stall) begin    // F/D holds on stall
				dPc    <= pc;
				dInstr <= instr;
			end
			// Bubble into execute while decode waits
			eInstr       <= stall ? '0 : dInstr;
			deReg.ctrl   <= stall ? '0 : dCtrl;
			deReg.pc     <= dPc;
			deReg.rsVal  <= dRs;
			deReg.rtVal  <= dRt;
			deReg.immExt <= dImmExt;
			mInstr       <= eInstr;
			emReg        <= '{ctrl: deReg.ctrl, pc: deReg.pc, aluResult: aluResult,
				rtVal: eRt};
			wInstr       <= mInstr;
			mwReg        <= '{ctrl: emReg.ctrl, pc: emReg.pc,
				result: emReg.ctrl.memRead ? memRData : emReg.aluResult};
		end
	end

	// ======================================================================
	// Retire strobes
	// ======================================================================
	assign regWrite = '{valid: mwReg.ctrl.regWrite, pc: mwReg.pc,
		addr: mwReg.ctrl.dest, data: mwReg.result};   // Also the register file port
	assign memWrite = '{valid: emReg.ctrl.memWrite, pc: emReg.pc,
		addr: emReg.aluResult, data: mRt};             // Store commits in M

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module regFile import cpu_pkg::*; (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [`REG_ADDR_W-1:0] rsAddr,
	input  logic [`REG_ADDR_W-1:0] rtAddr,
	output logic [`XLEN-1:0]       rsData,
	output logic [`XLEN-1:0]       rtData,
	input  regWriteT               wr
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	// Decode never flags a write to $0, so it stays zero from reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr.valid) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Write-through, decode sees the writeback of the same cycle
	assign rsData = (wr.valid && wr.addr == rsAddr) ? wr.data : regs[rsAddr];
	assign rtData = (wr.valid && wr.addr == rtAddr) ? wr.data : regs[rtAddr];

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module mipsCore_tb -o simv

# Keep going after assertion errors so the testbench gives the verdict
./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0

// ==== tests/mipsCore_chk.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module pipeAssertions import cpu_pkg::*; (
	input logic             clk,
	input logic             rstN,
	input logic             stall,
	input logic [`XLEN-1:0] instrAddr,
	input regWriteT         regWrite,
	input memWriteT         memWrite
);

	int unsigned failures = 0;   // Failed assertion count

	// $0 never retires a write
	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		regWrite.valid |-> regWrite.addr != '0)
		else begin
			failures++;
			$error("register write strobe names r0");
		end

	// Fetch PC frozen by a stall
	stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(instrAddr))
		else begin
			failures++;
			$error("fetch address moved after a stall cycle");
		end

	// Strobes quiet once reset has taken effect
	quietInReset: assert property (@(posedge clk)
		!rstN && !$past(rstN) |-> !regWrite.valid && !memWrite.valid)
		else begin
			failures++;
			$error("write strobe valid during reset");
		end

endmodule

bind mipsCore pipeAssertions iAsserts (.clk(clk), .rstN(rstN), .stall(stall),
	.instrAddr(instrAddr), .regWrite(regWrite), .memWrite(memWrite));

// ==== tests/mipsCore_tb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module mipsCore_tb import cpu_pkg::*; ();

	localparam int PROG_MAX = 128;

	logic             clk;
	logic             rstN;
	logic [`XLEN-1:0] instrAddr;
	logic [`XLEN-1:0] instr;
	regWriteT         regWrite;
	memWriteT         memWrite;

	// Program words and their fields
	logic [`XLEN-1:0]       prog     [PROG_MAX];
	opcodeT                 progKind [PROG_MAX];
	logic [`REG_ADDR_W-1:0] progRs   [PROG_MAX];
	logic [`REG_ADDR_W-1:0] progRt   [PROG_MAX];
	logic [`REG_ADDR_W-1:0] progRd   [PROG_MAX];
	logic [15:0]            progImm  [PROG_MAX];
	int                     progLen = 0;
	logic [`XLEN-1:0]       fetchIdx;

	// ISA model state and expected strobes
	logic [`XLEN-1:0] modelRegs [`REG_COUNT];
	logic [`XLEN-1:0] modelMem  [`DMEM_WORDS];
	regWriteT         expRegQ [$];
	memWriteT         expMemQ [$];

	int    seed     = 80;
	int    cycle    = 0;
	int    deadline = 0;
	int    errors   = 0;
	int    tests    = 0;
	logic  checking = 1'b0;   // Monitor on
	string testName = "none";

	mipsCore i_dut (.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
		.regWrite(regWrite), .memWrite(memWrite));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Instruction port, nop outside the program
	always_comb begin
		fetchIdx = (instrAddr - `RESET_PC) >> 2;
		if (instrAddr >= `RESET_PC && fetchIdx < progLen)
			instr = prog[fetchIdx];
		else
			instr = '0;
	end

	// ======================================================================
	// Program generation
	// ======================================================================
	function automatic int unsigned urand(input int unsigned span);
		return $unsigned($random(seed)) % span;
	endfunction

	// One weight nibble per kind, nop in the low nibble
	function automatic opcodeT pickKind(input logic [31:0] weights);
		int total;
		int r;
		total = 0;
		for (int k = 0; k < 8; k++)
			total += int'(weights[4*k +: 4]);
		r = int'(urand(total));
		for (int k = 0; k < 8; k++) begin
			if (r < int'(weights[4*k +: 4]))
				return opcodeT'(k);
			r -= int'(weights[4*k +: 4]);
		end
		return opNop;
	endfunction

	// MIPS encoding of slot i
	function automatic logic [`XLEN-1:0] encode(input int i);
		case (progKind[i])
			opAddu:  return {6'h00, progRs[i], progRt[i], progRd[i], 5'h00, 6'h21};
			opSubu:  return {6'h00, progRs[i], progRt[i], progRd[i], 5'h00, 6'h23};
			opOri:   return {6'h0d, progRs[i], progRt[i], progImm[i]};
			opLui:   return {6'h0f, 5'h00, progRt[i], progImm[i]};
			opLw:    return {6'h23, progRs[i], progRt[i], progImm[i]};
			opSw:    return {6'h2b, progRs[i], progRt[i], progImm[i]};
			opBeq:   return {6'h04, progRs[i], progRt[i], progImm[i]};
			default: return '0;
		endcase
	endfunction

	task automatic genProgram(input int len, input logic [31:0] weights, input int regSpan,
			input int memSpan);
		opcodeT k;
		for (int i = 0; i < len; i++) begin
			k = pickKind(weights);
			// No beq in a delay slot or without room ahead
			if (k == opBeq && (i > len - 2 || (i > 0 && progKind[i-1] == opBeq)))
				k = opAddu;
			progKind[i] = k;
			progRs[i]   = 5'(urand(regSpan));
			progRt[i]   = 5'(urand(regSpan));
			progRd[i]   = 5'(urand(regSpan));
			progImm[i]  = 16'(urand(32'h10000));
			if (k == opLui)
				progRs[i] = '0;
			if (k == opLw || k == opSw) begin
				progRs[i]  = '0;                    // Base $0
				progImm[i] = 16'(urand(memSpan) * 4);
			end
			if (k == opBeq)
				progImm[i] = 16'(1 + urand(len - 1 - i));   // Forward, at most the loop
			prog[i] = encode(i);
		end
		// Closing beq $0,$0 to itself and its delay slot
		progKind[len] = opBeq;
		progRs[len]   = '0;
		progRt[len]   = '0;
		progImm[len]  = 16'hffff;
		prog[len]     = encode(len);
		progKind[len+1] = opNop;
		prog[len+1]     = '0;
		progLen = len + 2;
	endtask

	// ======================================================================
	// ISA model
	// ======================================================================
	task automatic writeReg(input logic [`XLEN-1:0] pcVal, input logic [`REG_ADDR_W-1:0] r,
			input logic [`XLEN-1:0] value);
		if (r != '0) begin   // $0 discarded
			modelRegs[r] = value;
			expRegQ.push_back(regWriteT'{valid: 1'b1, pc: pcVal, addr: r, data: value});
		end
	endtask

	task automatic execOne(input int idx, output logic taken);
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] pcVal;
		a     = modelRegs[progRs[idx]];
		b     = modelRegs[progRt[idx]];
		pcVal = `RESET_PC + 4 * idx;
		taken = 1'b0;
		case (progKind[idx])
			opAddu: writeReg(pcVal, progRd[idx], a + b);
			opSubu: writeReg(pcVal, progRd[idx], a - b);
			opOri:  writeReg(pcVal, progRt[idx], a | {16'h0000, progImm[idx]});
			opLui:  writeReg(pcVal, progRt[idx], {progImm[idx], 16'h0000});
			opLw:   writeReg(pcVal, progRt[idx], modelMem[progImm[idx][`DMEM_ADDR_W+1:2]]);
			opSw: begin
				modelMem[progImm[idx][`DMEM_ADDR_W+1:2]] = b;
				expMemQ.push_back(memWriteT'{valid: 1'b1, pc: pcVal,
					addr: {16'h0000, progImm[idx]}, data: b});
			end
			opBeq:   taken = (a == b);
			default: ;
		endcase
	endtask

	// Sequential run up to the closing loop
	task automatic runModel(input int len);
		logic taken;
		logic slotTaken;
		int   i;
		for (int k = 0; k < `REG_COUNT; k++)
			modelRegs[k] = '0;
		for (int k = 0; k < `DMEM_WORDS; k++)
			modelMem[k] = '0;
		expRegQ.delete();
		expMemQ.delete();
		i = 0;
		while (i < len) begin
			execOne(i, taken);
			if (progKind[i] == opBeq) begin
				execOne(i + 1, slotTaken);   // Delay slot always runs
				i = taken ? i + 1 + int'(progImm[i]) : i + 2;
			end else begin
				i = i + 1;
			end
		end
	endtask

	// ======================================================================
	// Checks and monitor
	// ======================================================================
	task automatic checkRegWrite(input regWriteT exp, input regWriteT act);
		if (act !== exp) begin
			$display("Mismatch %s regWrite: expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
				testName, exp.pc, exp.addr, exp.data, act.pc, act.addr, act.data);
			errors++;
		end
	endtask

	task automatic checkMemWrite(input memWriteT exp, input memWriteT act);
		if (act !== exp) begin
			$display("Mismatch %s memWrite: expected pc=%h [%h]=%h, actual pc=%h [%h]=%h",
				testName, exp.pc, exp.addr, exp.data, act.pc, act.addr, act.data);
			errors++;
		end
	endtask

	// Strobes settle well before the falling edge
	always @(negedge clk) begin
		if (checking && regWrite.valid) begin
			if (expRegQ.size() == 0) begin
				$display("%s: register write to r%0d at pc %h when none was expected",
					testName, regWrite.addr, regWrite.pc);
				errors++;
			end else begin
				checkRegWrite(expRegQ.pop_front(), regWrite);
			end
		end
		if (checking && memWrite.valid) begin
			if (expMemQ.size() == 0) begin
				$display("%s: memory write to %h at pc %h when none was expected",
					testName, memWrite.addr, memWrite.pc);
				errors++;
			end else begin
				checkMemWrite(expMemQ.pop_front(), memWrite);
			end
		end
	end

	// Cycle counter and per-test deadline
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (checking && cycle >= deadline) begin
			$display("%s timed out at cycle %0d with %0d register and %0d memory writes pending",
				testName, cycle, expRegQ.size(), expMemQ.size());
			$display("%0d tests run, %0d errors", tests,
				errors + 1 + int'(i_dut.iAsserts.failures));
			$display("Test FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Test sequencing
	// ======================================================================
	task automatic applyReset();
		@(posedge clk);
		#1 rstN = 1'b0;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
	endtask

	// cutAfter above zero resets the core mid-program
	task automatic runTest(input string name, input int len, input logic [31:0] weights,
			input int regSpan, input int memSpan, input int cutAfter);
		int errStart;
		int nReg;
		int nMem;
		checking = 1'b0;
		testName = name;
		genProgram(len, weights, regSpan, memSpan);
		runModel(len);
		nReg     = expRegQ.size();
		nMem     = expMemQ.size();
		errStart = errors;
		applyReset();
		deadline = cycle + 8 * progLen + 20;
		checking = 1'b1;
		if (cutAfter > 0) begin
			repeat (cutAfter) @(posedge clk);
			#1;
			checking = 1'b0;
			$display("%s: reset after %0d cycles with %0d writes queued, %0d errors", name,
				cutAfter, expRegQ.size() + expMemQ.size(), errors - errStart);
		end else begin
			while (expRegQ.size() + expMemQ.size() > 0)
				@(posedge clk);
			repeat (10) @(posedge clk);   // Stray writes show up here
			#1;
			checking = 1'b0;
			$display("%s: %0d instructions, %0d register and %0d memory writes, %0d errors",
				name, len, nReg, nMem, errors - errStart);
		end
		tests++;
	endtask

	initial begin
		int total;
		rstN = 1'b0;
		for (int i = 0; i < PROG_MAX; i++)
			prog[i] = '0;
		// Weights by nibble: beq sw lw lui ori subu addu nop
		runTest("arith",      24, 32'h0003_3330, 8, 16, 0);
		runTest("forward",    32, 32'h0001_3340, 4, 16, 0);
		runTest("memory",     32, 32'h0440_2010, 8, 8, 0);
		runTest("loadUse",    40, 32'h2240_1120, 4, 4, 0);
		runTest("branch",     40, 32'h4000_2231, 4, 16, 0);
		runTest("midReset",   48, 32'h2231_2231, 8, 16, 60);
		runTest("afterReset", 40, 32'h2231_2231, 8, 16, 0);
		runTest("mixedA",     60, 32'h2231_2231, 8, 16, 0);
		runTest("mixedB",     60, 32'h2231_2231, 4, 8, 0);
		total = errors + int'(i_dut.iAsserts.failures);
		$display("%0d tests run, %0d errors", tests, total);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
logic/cpu_pkg.sv
logic/instrDecode.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/execUnit.sv
logic/dataMem.sv
logic/mipsCore.sv
tests/mipsCore_chk.sv
tests/mipsCore_tb.sv
